//--- design/ssb_consts.svh
`ifndef SSB_CONSTS_SVH
`define SSB_CONSTS_SVH

// width of the interleaved I/Q drive word from the controller
`define SSB_DRIVE_W 18

// width of the held I and Q samples, one bit of headroom over the 16 kept drive bits
`define SSB_IQ_W 17

// width of the local oscillator cos and sin values
`define SSB_LO_W 18

// width of every word sent to a DAC
`define SSB_DAC_W 16

// number of mixing lanes, each one feeding its own DAC channel
`define SSB_N_LANES 2

// midpoint coefficient in units of 1/32768, about 0.5*sec(pi*16/101)
`define SSB_AB_COEFF 18646

`endif

//--- design/ssb_pkg.sv
`include "ssb_consts.svh"

package ssb_pkg;

	// held I or Q sample as seen by the mixers
	typedef logic signed [`SSB_IQ_W-1:0] iq_sample_t;

	// one local oscillator component, cos or sin
	typedef logic signed [`SSB_LO_W-1:0] lo_sample_t;

	// one two's-complement DAC word
	typedef logic signed [`SSB_DAC_W-1:0] dac_word_t;

	// the two words a lane hands to the DAC in one clock
	// w0 goes out on the sample, w1 is the interpolated midpoint after it
	typedef struct packed {
		dac_word_t w0;
		dac_word_t w1;
	} dac_pair_t;

endpackage

//--- design/iq_lo_if.sv
`timescale 1ns/1ns

// aligned baseband pair plus the LO that goes with it
// the values are refreshed every clock and carry no strobe
interface iq_lo_if;
	import ssb_pkg::*;

	// held I and Q, updated together once per I/Q frame
	iq_sample_t i_val;
	iq_sample_t q_val;

	// LO registered on the same edge as the pair
	lo_sample_t cos_val;
	lo_sample_t sin_val;

	// the de-interleaver owns every signal
	modport src (
		output i_val, q_val, cos_val, sin_val
	);

	// every lane only reads
	modport snk (
		input i_val, q_val, cos_val, sin_val
	);
endinterface

//--- design/iq_deinterleave.sv
`timescale 1ns/1ns
`include "ssb_consts.svh"

module iq_deinterleave (
	input  logic                          clk,
	input  logic                          i_rst,
	input  logic [1:0]                    i_div_state,
	input  logic signed [`SSB_DRIVE_W-1:0] i_drive,
	input  ssb_pkg::lo_sample_t           i_cosa,
	input  ssb_pkg::lo_sample_t           i_sina,
	iq_lo_if.src                          o_iq
);
	import ssb_pkg::*;

	// only the upper drive bits carry useful resolution
	localparam int lp_keep_w = 16;

	// bit 0 of the divider state is high on the I slot of the stream
	logic       is_i_phase;

	// drive word after truncation and sign extension
	iq_sample_t drive_ext;

	// I captured on its own slot, waiting for the matching Q
	iq_sample_t i_hold;

	assign is_i_phase = i_div_state[0];

	// keep the top bits and extend by one so the lane has headroom for ~I
	assign drive_ext = iq_sample_t'($signed(i_drive[`SSB_DRIVE_W-1 -: lp_keep_w]));

	always_ff @(posedge clk) begin
		if (i_rst) begin
			i_hold       <= '0;
			o_iq.i_val   <= '0;
			o_iq.q_val   <= '0;
			o_iq.cos_val <= '0;
			o_iq.sin_val <= '0;
		end else begin
			// the LO is retimed every clock so it lines up with the held pair
			o_iq.cos_val <= i_cosa;
			o_iq.sin_val <= i_sina;
			if (is_i_phase) begin
				// I alone is never published, the mixers keep the old pair
				i_hold <= drive_ext;
			end else begin
				// Q slot completes the frame, so I and Q change on the same edge
				o_iq.i_val <= i_hold;
				o_iq.q_val <= drive_ext;
			end
		end
	end

endmodule

//--- design/ssb_lane.sv
`timescale 1ns/1ns
`include "ssb_consts.svh"

module ssb_lane #(
	parameter int p_quadrature = 0
) (
	input  logic               clk,
	input  logic               i_rst,
	iq_lo_if.snk               i_iq,
	output ssb_pkg::dac_pair_t o_pair
);
	import ssb_pkg::*;

	// widths of the LO mixer path
	localparam int lp_prod_w = `SSB_IQ_W + `SSB_LO_W;
	localparam int lp_sum_w = lp_prod_w + 1;
	localparam int lp_mix_shift = 17;

	// widths of the midpoint path, the coefficient fits a 16 bit signed value
	localparam int lp_coeff_w = 16;
	localparam int lp_mid_sum_w = `SSB_DAC_W + 1;
	localparam int lp_mid_prod_w = lp_mid_sum_w + lp_coeff_w;
	localparam int lp_ab_shift = 15;

	// container wide enough for either path before saturation
	localparam int lp_wide_w = 48;

	localparam logic signed [lp_coeff_w-1:0] lp_coeff = `SSB_AB_COEFF;
	localparam logic signed [lp_sum_w-1:0] lp_mix_half = 1 <<< (lp_mix_shift - 1);
	localparam logic signed [lp_mid_prod_w-1:0] lp_ab_half = 1 <<< (lp_ab_shift - 1);
	localparam logic signed [lp_wide_w-1:0] lp_dac_max = 2 ** (`SSB_DAC_W - 1) - 1;
	localparam logic signed [lp_wide_w-1:0] lp_dac_min = -(2 ** (`SSB_DAC_W - 1));

	// clip a wide signed value into the DAC range
	function automatic dac_word_t sat_dac(input logic signed [lp_wide_w-1:0] v);
		dac_word_t r;
		if (v > lp_dac_max) begin
			r = dac_word_t'(lp_dac_max);
		end else if (v < lp_dac_min) begin
			r = dac_word_t'(lp_dac_min);
		end else begin
			r = dac_word_t'(v);
		end
		return r;
	endfunction

	iq_sample_t                      op_a;
	iq_sample_t                      op_b;
	logic signed [lp_prod_w-1:0]     p_cos;
	logic signed [lp_prod_w-1:0]     p_sin;
	logic signed [lp_sum_w-1:0]      mix_sum;
	logic signed [lp_sum_w-1:0]      mix_rnd;
	dac_word_t                       word_cur;
	dac_word_t                       word_prev;
	logic signed [lp_mid_sum_w-1:0]  mid_sum;
	logic signed [lp_mid_prod_w-1:0] mid_prod;
	logic signed [lp_mid_prod_w-1:0] mid_rnd;

	// the quadrature lane swaps in Q for I and ~I for Q, a 90 degree turn of the pair
	assign op_a = (p_quadrature != 0) ? i_iq.q_val : i_iq.i_val;
	assign op_b = (p_quadrature != 0) ? ~i_iq.i_val : i_iq.q_val;

	// sum of the two products, rounded half up on the 17 bit drop
	assign mix_sum = p_cos + p_sin;
	assign mix_rnd = (mix_sum + lp_mix_half) >>> lp_mix_shift;

	// midpoint between consecutive on-sample words, scaled to undo the sinc droop
	assign mid_sum = word_cur + word_prev;
	assign mid_prod = mid_sum * lp_coeff;
	assign mid_rnd = (mid_prod + lp_ab_half) >>> lp_ab_shift;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			p_cos     <= '0;
			p_sin     <= '0;
			word_cur  <= '0;
			word_prev <= '0;
			o_pair    <= '0;
		end else begin
			// first stage holds the raw LO products
			p_cos <= op_a * i_iq.cos_val;
			p_sin <= op_b * i_iq.sin_val;
			// second stage is the saturated on-sample word
			word_cur  <= sat_dac(mix_rnd);
			word_prev <= word_cur;
			// DDR pair, the older word first and then the point halfway to the newer one
			o_pair.w0 <= word_prev;
			o_pair.w1 <= sat_dac(mid_rnd);
		end
	end

endmodule

//--- design/dac_ddr_out.sv
`timescale 1ns/1ns
`include "ssb_consts.svh"

module dac_ddr_out (
	input  logic               clk,
	input  logic               i_rst,
	input  logic               i_enable,
	input  ssb_pkg::dac_pair_t i_pairs [`SSB_N_LANES],
	output ssb_pkg::dac_pair_t o_pairs [`SSB_N_LANES]
);

	// enable is sampled on the same edge as the data it gates
	// so every channel turns on and off in the same clock
	always_ff @(posedge clk) begin
		if (i_rst) begin
			for (int n = 0; n < `SSB_N_LANES; n++) begin
				o_pairs[n] <= '0;
			end
		end else if (!i_enable) begin
			// a disabled output drives mid-scale, which is zero in two's complement
			for (int n = 0; n < `SSB_N_LANES; n++) begin
				o_pairs[n] <= '0;
			end
		end else begin
			// both DDR words of a lane move together toward the pins
			for (int n = 0; n < `SSB_N_LANES; n++) begin
				o_pairs[n] <= i_pairs[n];
			end
		end
	end

endmodule

//--- design/ssb_out.sv
`timescale 1ns/1ns
`include "ssb_consts.svh"

// two-channel SSB output for close-in RF hardware
// lane 0 drives DAC 1 with the in-phase mix, lane 1 drives DAC 2 with the quadrature mix
module ssb_out (
	input  logic                          clk,
	input  logic                          i_rst,
	input  logic [1:0]                    i_div_state,
	input  logic signed [`SSB_DRIVE_W-1:0] i_drive,
	input  logic                          i_enable,
	input  ssb_pkg::lo_sample_t           i_cosa,
	input  ssb_pkg::lo_sample_t           i_sina,
	output logic signed [`SSB_DAC_W-1:0]   o_dac1_out0,
	output logic signed [`SSB_DAC_W-1:0]   o_dac1_out1,
	output logic signed [`SSB_DAC_W-1:0]   o_dac2_out0,
	output logic signed [`SSB_DAC_W-1:0]   o_dac2_out1
);
	import ssb_pkg::*;

	// aligned pair and LO shared by every lane
	iq_lo_if iq_bus ();

	// pairs straight out of the lanes, then after gating and retiming
	dac_pair_t lane_pairs [`SSB_N_LANES];
	dac_pair_t dac_pairs [`SSB_N_LANES];

	// half-rate interleaved drive becomes a held full-rate pair
	iq_deinterleave u_deinterleave (
		.clk         (clk),
		.i_rst       (i_rst),
		.i_div_state (i_div_state),
		.i_drive     (i_drive),
		.i_cosa      (i_cosa),
		.i_sina      (i_sina),
		.o_iq        (iq_bus.src)
	);

	// the lane index selects the in-phase or the quadrature operand set
	for (genvar g = 0; g < `SSB_N_LANES; g++) begin : g_lane
		ssb_lane #(
			.p_quadrature (g)
		) u_lane (
			.clk    (clk),
			.i_rst  (i_rst),
			.i_iq   (iq_bus.snk),
			.o_pair (lane_pairs[g])
		);
	end

	dac_ddr_out u_drain (
		.clk      (clk),
		.i_rst    (i_rst),
		.i_enable (i_enable),
		.i_pairs  (lane_pairs),
		.o_pairs  (dac_pairs)
	);

	// out0 is the on-sample word and out1 the midpoint for each DAC
	assign o_dac1_out0 = dac_pairs[0].w0;
	assign o_dac1_out1 = dac_pairs[0].w1;
	assign o_dac2_out0 = dac_pairs[1].w0;
	assign o_dac2_out1 = dac_pairs[1].w1;

endmodule

//--- test/ssb_out_tb.sv
`timescale 1ns/1ns
`include "ssb_consts.svh"

module ssb_out_tb;

	localparam int lp_period = 4;
	localparam int lp_latency = 5;
	localparam int lp_reset_cycles = 4;

	logic                          clk;
	logic                          i_rst;
	logic [1:0]                    i_div_state;
	logic signed [`SSB_DRIVE_W-1:0] i_drive;
	logic                          i_enable;
	logic signed [`SSB_LO_W-1:0]   i_cosa;
	logic signed [`SSB_LO_W-1:0]   i_sina;
	logic signed [`SSB_DAC_W-1:0]  o_dac1_out0;
	logic signed [`SSB_DAC_W-1:0]  o_dac1_out1;
	logic signed [`SSB_DAC_W-1:0]  o_dac2_out0;
	logic signed [`SSB_DAC_W-1:0]  o_dac2_out1;

	// vectors from the file with four expected words per vector kept flat
	string names[$];
	int    div_q[$];
	int    drive_q[$];
	int    cos_q[$];
	int    sin_q[$];
	int    en_q[$];
	int    exp_q[$];
	bit    chk_q[$];

	// indices of driven vectors whose outputs are still in the pipeline
	int    pending[$];
	int    n_vec;
	bit    loaded;
	int    mismatches;
	int    other_errors;

	ssb_out dut (
		.clk         (clk),
		.i_rst       (i_rst),
		.i_div_state (i_div_state),
		.i_drive     (i_drive),
		.i_enable    (i_enable),
		.i_cosa      (i_cosa),
		.i_sina      (i_sina),
		.o_dac1_out0 (o_dac1_out0),
		.o_dac1_out1 (o_dac1_out1),
		.o_dac2_out0 (o_dac2_out0),
		.o_dac2_out1 (o_dac2_out1)
	);

	initial begin
		clk = 1'b0;
		forever #(lp_period / 2) clk = ~clk;
	end

	// a DAC word that carries X or Z bits never matches the expected value
	task automatic check_word(input string name, input string port, input int exp,
		input logic signed [`SSB_DAC_W-1:0] act);
		if (act !== exp) begin
			$display("FAILED %s %s expected %0d actual %0d", name, port, exp, act);
			mismatches++;
		end
	endtask

	// all four DAC words must sit at zero
	task automatic check_idle(input string name);
		check_word(name, "dac1_out0", 0, o_dac1_out0);
		check_word(name, "dac1_out1", 0, o_dac1_out1);
		check_word(name, "dac2_out0", 0, o_dac2_out0);
		check_word(name, "dac2_out1", 0, o_dac2_out1);
	endtask

	// the words of vector j sit at base, base+1, base+2 and base+3 in the flat queues
	task automatic compare_vector(input int j);
		int base;
		base = j * 4;
		if (chk_q[base]) check_word(names[j], "dac1_out0", exp_q[base], o_dac1_out0);
		if (chk_q[base+1]) check_word(names[j], "dac1_out1", exp_q[base+1], o_dac1_out1);
		if (chk_q[base+2]) check_word(names[j], "dac2_out0", exp_q[base+2], o_dac2_out0);
		if (chk_q[base+3]) check_word(names[j], "dac2_out1", exp_q[base+3], o_dac2_out1);
	endtask

	// only the low bits of the divider state and the enable column reach the DUT
	task automatic drive_vector(input int k);
		i_div_state = 2'(div_q[k]);
		i_drive     = drive_q[k];
		i_cosa      = cos_q[k];
		i_sina      = sin_q[k];
		i_enable    = 1'(en_q[k]);
	endtask

	task automatic load_vectors();
		int    fd;
		int    code;
		int    dv;
		int    dr;
		int    c;
		int    s;
		int    en;
		int    v;
		string tok;
		string line;
		string etok;
		fd = $fopen("test/ssb_out_tests.txt", "r");
		if (fd == 0) begin
			$display("error: cannot open the vector file test/ssb_out_tests.txt");
			other_errors++;
			return;
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", tok);
			if (code != 1) break;
			if (tok.substr(0, 0) == "#") begin
				// a comment runs to the end of its line
				code = $fgets(line, fd);
			end else begin
				code = $fscanf(fd, "%d %d %d %d %d", dv, dr, c, s, en);
				if (code != 5) begin
					$display("error: vector %s has fewer than five input columns", tok);
					other_errors++;
					break;
				end
				names.push_back(tok);
				div_q.push_back(dv);
				drive_q.push_back(dr);
				cos_q.push_back(c);
				sin_q.push_back(s);
				en_q.push_back(en);
				for (int w = 0; w < 4; w++) begin
					code = $fscanf(fd, "%s", etok);
					if (code != 1) begin
						$display("error: vector %s is missing expected words", tok);
						other_errors++;
						exp_q.push_back(0);
						chk_q.push_back(1'b0);
					end else if (etok == "x") begin
						// x marks a word that is not checked on this line
						exp_q.push_back(0);
						chk_q.push_back(1'b0);
					end else begin
						code = $sscanf(etok, "%d", v);
						exp_q.push_back(v);
						chk_q.push_back(1'b1);
					end
				end
			end
		end
		$fclose(fd);
		n_vec = names.size();
		if (n_vec == 0) begin
			$display("error: the vector file holds no vectors");
			other_errors++;
		end
	endtask

	initial begin
		int k;
		int j;
		i_rst        = 1'b1;
		i_div_state  = 2'b00;
		i_drive      = '0;
		i_enable     = 1'b0;
		i_cosa       = '0;
		i_sina       = '0;
		mismatches   = 0;
		other_errors = 0;
		n_vec        = 0;
		loaded       = 1'b0;
		load_vectors();
		loaded = 1'b1;
		// every output must read zero while reset is held
		repeat (lp_reset_cycles) begin
			@(posedge clk);
			#1;
			check_idle("reset");
		end
		i_rst = 1'b0;
		// a vector driven here is sampled on the next edge and seen five edges after that
		for (k = 0; k < n_vec + lp_latency + 1; k++) begin
			@(posedge clk);
			#1;
			if (pending.size() == lp_latency + 1 || (k >= n_vec && pending.size() > 0)) begin
				j = pending.pop_front();
				compare_vector(j);
			end else if (k < lp_latency + 1) begin
				// the pipeline still holds reset values here
				check_idle("after_reset");
			end
			if (k < n_vec) begin
				drive_vector(k);
				pending.push_back(k);
			end
		end
		$display("errors: %0d mismatches, %0d other", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// the run length follows from the number of vectors once they are read
	initial begin
		wait (loaded);
		#((n_vec + 20) * lp_period);
		$display("timeout: the run did not finish within %0d cycles", n_vec + 20);
		$display("Regression failed");
		$finish;
	end

endmodule

//--- test/ssb_out_tests.txt
# name div_state drive cos sin enable dac1_out0 dac1_out1 dac2_out0 dac2_out1
# expected words are the outputs 5 cycles after the line is sampled, x means unchecked
start 1 4000 65536 0 1 x x x x
mix_l1 0 2400 65536 0 1 500 569 300 341
mix_l1 1 4000 65536 0 1 500 569 300 341
mix_l1 0 2400 65536 0 1 500 455 300 -114
# stepped LO with I=1000 Q=600 held
mix_l2 1 4000 0 65536 1 300 341 -500 -569
mix_l2 0 2400 0 65536 1 300 626 -500 -398
mix_l3 1 4000 65536 65536 1 800 910 -200 -228
mix_l3 0 2400 65536 65536 1 800 256 -200 -427
mix_l4 1 4000 -65536 32768 1 -350 -398 -550 -626
mix_l4 0 2400 -65536 32768 1 -350 -398 -550 -626
# a new I alone must not reach the mixers
hold_i 1 131068 -65536 32768 1 -350 18446 -550 -314
# full scale I and Q with full scale LO saturate lane 0
sat_full 0 131068 131071 131071 1 32767 32767 -1 -1
sat_full 1 131068 131071 131071 1 32767 32767 -1 -1
sat_full 0 131068 131071 131071 1 32767 32767 -1 -1
sat_full 1 131068 131071 131071 1 32767 32767 -1 -1
sat_full 0 131068 131071 131071 1 32767 27968 -1 9322
restore 1 4000 65536 0 1 16384 9608 16384 9494
# enable drops on gate lines 22 and 23, gating outputs of the two lines 5 earlier
gate_off 0 2400 65536 0 1 0 0 0 0
gate_off 1 4000 65536 0 1 0 0 0 0
gate_on 0 2400 65536 0 1 500 569 300 341
gate_on 1 4000 65536 0 1 500 569 300 341
gate_on 0 2400 65536 0 1 500 569 300 341
gate_low 1 4000 65536 0 0 500 569 300 341
gate_low 0 2400 65536 0 0 500 569 300 341
gate_on 1 4000 65536 0 1 500 569 300 341
gate_on 0 2400 65536 0 1 500 569 300 341

//--- ssb_out.f
+incdir+design
design/ssb_pkg.sv
design/iq_lo_if.sv
design/iq_deinterleave.sv
design/ssb_lane.sv
design/dac_ddr_out.sv
design/ssb_out.sv
test/ssb_out_tb.sv

//--- Bender.yml
package:
  name: ssb_out

sources:
  - include_dirs:
      - design
    files:
      - design/ssb_pkg.sv
      - design/iq_lo_if.sv
      - design/iq_deinterleave.sv
      - design/ssb_lane.sv
      - design/dac_ddr_out.sv
      - design/ssb_out.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/ssb_out_tb.sv
